// ==== hdl/kmouse_pkg.sv ====
`default_nettype none

package kmouse_pkg;

    //////////////////////////////////////////////////
    // PS/2 side
    //////////////////////////////////////////////////

    // One byte as it leaves the serial receiver
    typedef struct packed {
        logic [7:0] data;
    } ps2_byte_t;

    //////////////////////////////////////////////////
    // Kempston side
    //////////////////////////////////////////////////

    // Buttons are active low: bits 7..3 stuck at 1,
    // then middle, left, right in bits 2, 1, 0
    typedef struct packed {
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] buttons;
    } kmouse_pos_t;

    // Host-visible options that the decoder obeys
    typedef struct packed {
        logic swap_buttons;
        logic invert_y;
    } kmouse_cfg_t;

    // Host register select
    typedef enum logic [1:0] {
        KM_ADDR_X       = 2'd0,
        KM_ADDR_Y       = 2'd1,
        KM_ADDR_BUTTONS = 2'd2,
        KM_ADDR_CFG     = 2'd3
    } kmouse_addr_e;

    // No button pressed
    localparam logic [7:0] KM_BUTTONS_IDLE = 8'hFF;

endpackage

`default_nettype wire

// ==== hdl/ps2_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_rx #(
    parameter int TIMEOUT_CYCLES = 2**20
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ps2_clk,
    input  logic                  ps2_data,
    output kmouse_pkg::ps2_byte_t byte_out,
    output logic                  byte_valid
);

    localparam int TW = $clog2(TIMEOUT_CYCLES + 1);

    // Two-flop synchronizers, bit 1 is the safe one
    logic [1:0]    clk_sync;
    logic [1:0]    data_sync;
    logic          clk_prev;
    logic          clk_fall;

    // Frame shifter: bit 0 start, 8..1 data, 9 parity, 10 stop
    logic [10:0]   shift;
    logic [3:0]    bit_cnt;
    logic          frame_done;
    logic          frame_ok;
    logic [TW-1:0] idle_cnt;

    //////////////////////////////////////////////////
    // Line synchronization and edge detect
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];

    //////////////////////////////////////////////////
    // Bit capture
    //////////////////////////////////////////////////

    // LSB arrives first, so shift right
    always_ff @(posedge clk) begin
        if (clk_fall) begin
            shift <= {data_sync[1], shift[10:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt    <= 4'd0;
            frame_done <= 1'b0;
            idle_cnt   <= '0;
        end else begin
            frame_done <= 1'b0;
            if (clk_fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= 4'd0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                // Mouse went quiet mid-frame
                if (idle_cnt == TW'(TIMEOUT_CYCLES - 1)) begin
                    bit_cnt  <= 4'd0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end else begin
                idle_cnt <= '0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Frame check
    //////////////////////////////////////////////////

    // Start low, stop high, odd parity over data + parity
    assign frame_ok = ~shift[0] & shift[10] & (^shift[9:1]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= frame_done & frame_ok;
        end
    end

    // Shifter holds still until the next falling edge
    assign byte_out.data = shift[8:1];

endmodule

`default_nettype wire

// ==== hdl/ps2_packet_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_packet_decoder #(
    parameter int TIMEOUT_CYCLES = 2**20
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  kmouse_pkg::ps2_byte_t   byte_in,
    input  logic                    byte_valid,
    input  kmouse_pkg::kmouse_cfg_t cfg,
    output kmouse_pkg::kmouse_pos_t pos
);

    localparam int TW = $clog2(TIMEOUT_CYCLES + 1);

    typedef enum logic [1:0] {
        ST_BYTE1  = 2'd0,
        ST_BYTE2  = 2'd1,
        ST_BYTE3  = 2'd2,
        ST_UPDATE = 2'd3
    } state_t;

    state_t        state;
    logic [TW-1:0] idle_cnt;
    logic          idle_expired;

    // Packet fields held until the update state
    logic [2:0]    btn_raw;
    logic [7:0]    dx;
    logic [7:0]    dy;

    logic [7:0]    btn_next;
    logic [7:0]    x_next;
    logic [7:0]    y_next;

    //////////////////////////////////////////////////
    // Packet capture
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            case (state)
                ST_BYTE1: btn_raw <= byte_in.data[2:0];
                ST_BYTE2: dx      <= byte_in.data;
                ST_BYTE3: dy      <= byte_in.data;
                default:  ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Next position
    //////////////////////////////////////////////////

    // PS/2 byte one: bit 0 left, bit 1 right, bit 2 middle
    always_comb begin
        if (cfg.swap_buttons) begin
            btn_next = {5'b11111, ~btn_raw[2], ~btn_raw[1], ~btn_raw[0]};
        end else begin
            btn_next = {5'b11111, ~btn_raw[2], ~btn_raw[0], ~btn_raw[1]};
        end
    end

    // Wrap modulo 256, sign bits not needed
    assign x_next = pos.x + dx;
    assign y_next = cfg.invert_y ? (pos.y - dy) : (pos.y + dy);

    //////////////////////////////////////////////////
    // Packet FSM
    //////////////////////////////////////////////////

    assign idle_expired = (idle_cnt == TW'(TIMEOUT_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_BYTE1;
            idle_cnt    <= '0;
            pos.x       <= 8'h00;
            pos.y       <= 8'h00;
            pos.buttons <= kmouse_pkg::KM_BUTTONS_IDLE;
        end else begin
            case (state)
                ST_BYTE1: begin
                    idle_cnt <= '0;
                    // Bit 3 is always set in a real first byte
                    if (byte_valid && byte_in.data[3]) begin
                        state <= ST_BYTE2;
                    end
                end
                ST_BYTE2: begin
                    if (byte_valid) begin
                        idle_cnt <= '0;
                        state    <= ST_BYTE3;
                    end else if (idle_expired) begin
                        idle_cnt <= '0;
                        state    <= ST_BYTE1;
                    end else begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end
                ST_BYTE3: begin
                    if (byte_valid) begin
                        idle_cnt <= '0;
                        state    <= ST_UPDATE;
                    end else if (idle_expired) begin
                        idle_cnt <= '0;
                        state    <= ST_BYTE1;
                    end else begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end
                ST_UPDATE: begin
                    pos.x       <= x_next;
                    pos.y       <= y_next;
                    pos.buttons <= btn_next;
                    idle_cnt    <= '0;
                    state       <= ST_BYTE1;
                end
                default: begin
                    state <= ST_BYTE1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/kmouse_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module kmouse_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  kmouse_pkg::kmouse_addr_e addr,
    input  logic                     rd,
    input  logic                     wr,
    input  logic [7:0]               wdata,
    input  kmouse_pkg::kmouse_pos_t  pos,
    output kmouse_pkg::kmouse_cfg_t  cfg,
    output logic [7:0]               rdata,
    output logic                     rdata_valid
);

    logic [7:0] rd_mux;

    //////////////////////////////////////////////////
    // Configuration register
    //////////////////////////////////////////////////

    // Bit 1 swap buttons, bit 0 invert Y
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (wr && (addr == kmouse_pkg::KM_ADDR_CFG)) begin
            cfg <= kmouse_pkg::kmouse_cfg_t'(wdata[1:0]);
        end
    end

    //////////////////////////////////////////////////
    // Host read port
    //////////////////////////////////////////////////

    always_comb begin
        case (addr)
            kmouse_pkg::KM_ADDR_X:       rd_mux = pos.x;
            kmouse_pkg::KM_ADDR_Y:       rd_mux = pos.y;
            kmouse_pkg::KM_ADDR_BUTTONS: rd_mux = pos.buttons;
            kmouse_pkg::KM_ADDR_CFG:     rd_mux = {6'b000000, cfg};
            default:                     rd_mux = 8'h00;
        endcase
    end

    // Value seen at the rd edge, so a same-cycle write reads old cfg
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata       <= 8'h00;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= rd;
            if (rd) begin
                rdata <= rd_mux;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/kmouse_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module kmouse_top #(
    parameter int TIMEOUT_CYCLES = 2**20
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     ps2_clk,
    input  logic                     ps2_data,
    input  kmouse_pkg::kmouse_addr_e addr,
    input  logic                     rd,
    input  logic                     wr,
    input  logic [7:0]               wdata,
    output logic [7:0]               rdata,
    output logic                     rdata_valid
);

    kmouse_pkg::ps2_byte_t   rx_byte;
    logic                    rx_valid;
    kmouse_pkg::kmouse_pos_t pos;
    kmouse_pkg::kmouse_cfg_t cfg;

    // Serial frames in, checked bytes out
    ps2_rx #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) ps2_rx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .byte_out   (rx_byte),
        .byte_valid (rx_valid)
    );

    // Three-byte packets to Kempston position
    ps2_packet_decoder #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) ps2_packet_decoder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_in    (rx_byte),
        .byte_valid (rx_valid),
        .cfg        (cfg),
        .pos        (pos)
    );

    kmouse_regs kmouse_regs_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (addr),
        .rd          (rd),
        .wr          (wr),
        .wdata       (wdata),
        .pos         (pos),
        .cfg         (cfg),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

endmodule

`default_nettype wire

// ==== tb/tb_kmouse.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_kmouse;

    localparam int     CLK_PERIOD  = 8;
    localparam int     TIMEOUT     = 4000;
    localparam int     BIT_CYCLES  = 40;
    localparam int     BYTE_GAP    = 60;
    localparam int     PACKET_GAP  = 100;
    localparam int     READ_WAIT   = 8;
    localparam int     NUM_PACKETS = 40 + 3 * 5 + 6;
    // One frame is 11 PS/2 bits plus the gap after it
    localparam int     FRAME_CYCLES  = 11 * BIT_CYCLES + BYTE_GAP;
    localparam int     PACKET_CYCLES = 3 * FRAME_CYCLES + PACKET_GAP + 50;
    localparam longint WATCHDOG_CYCLES =
        NUM_PACKETS * PACKET_CYCLES * 3 / 2 + 3 * (TIMEOUT + 2 * FRAME_CYCLES) + 200;

    logic                     clk;
    logic                     rst_n;
    logic                     ps2_clk;
    logic                     ps2_data;
    kmouse_pkg::kmouse_addr_e addr;
    logic                     rd;
    logic                     wr;
    logic [7:0]               wdata;
    logic [7:0]               rdata;
    logic                     rdata_valid;

    // Expected state kept beside the DUT
    kmouse_pkg::kmouse_pos_t  model_pos;
    kmouse_pkg::kmouse_cfg_t  model_cfg;
    kmouse_pkg::kmouse_pos_t  exp_pos;
    logic [31:0]              lfsr_state = 32'h2b2acd76;
    int                       pkt_posted = 0;
    int                       pkt_checked = 0;
    int                       pos_errors = 0;
    int                       cfg_errors = 0;
    int                       strobe_errors = 0;

    kmouse_top #(
        .TIMEOUT_CYCLES (TIMEOUT)
    ) kmouse_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .addr        (addr),
        .rd          (rd),
        .wr          (wr),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Random bytes and reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA3000000;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit
    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
        return b;
    endfunction

    // Byte one carries left in bit 0, right in bit 1 and middle in bit 2
    function automatic kmouse_pkg::kmouse_pos_t kmouse_model(
        input kmouse_pkg::kmouse_pos_t prev,
        input logic [7:0]              b1,
        input logic [7:0]              b2,
        input logic [7:0]              b3,
        input kmouse_pkg::kmouse_cfg_t cfg
    );
        kmouse_pkg::kmouse_pos_t next;
        logic                    left;
        logic                    right;
        left  = cfg.swap_buttons ? b1[1] : b1[0];
        right = cfg.swap_buttons ? b1[0] : b1[1];
        next.x = prev.x + b2;
        if (cfg.invert_y) begin
            next.y = prev.y - b3;
        end else begin
            next.y = prev.y + b3;
        end
        next.buttons = {5'b11111, ~b1[2], ~left, ~right};
        return next;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_pos(
        input kmouse_pkg::kmouse_pos_t exp,
        input kmouse_pkg::kmouse_pos_t act
    );
        if (act !== exp) begin
            pos_errors++;
            $display("ERR pos expected 0x%06h actual 0x%06h", exp, act);
        end
    endtask

    task automatic check_cfg(
        input kmouse_pkg::kmouse_cfg_t exp,
        input kmouse_pkg::kmouse_cfg_t act
    );
        if (act !== exp) begin
            cfg_errors++;
            $display("ERR cfg expected 0x%01h actual 0x%01h", exp, act);
        end
    endtask

    task automatic check_rdata_valid(input logic seen, input kmouse_pkg::kmouse_addr_e a);
        if (!seen) begin
            strobe_errors++;
            $display("No read strobe came back for register %0d", a);
        end
    endtask

    //////////////////////////////////////////////////
    // Bus and PS/2 drivers
    //////////////////////////////////////////////////

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic host_read(input kmouse_pkg::kmouse_addr_e a, output logic [7:0] d);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        d      = 8'h00;
        @(negedge clk);
        addr = a;
        rd   = 1'b1;
        @(negedge clk);
        rd = 1'b0;
        while (!seen && waited < READ_WAIT) begin
            if (rdata_valid) begin
                seen = 1'b1;
                d    = rdata;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        check_rdata_valid(seen, a);
    endtask

    // Config reads back with zeros above bit 1
    task automatic readback_cfg(input kmouse_pkg::kmouse_cfg_t c);
        logic [7:0] d;
        host_read(kmouse_pkg::KM_ADDR_CFG, d);
        check_cfg(c, kmouse_pkg::kmouse_cfg_t'(d[1:0]));
        if (d[7:2] !== 6'b000000) begin
            cfg_errors++;
            $display("ERR rdata expected 0x%02h actual 0x%02h", {6'b000000, c}, d);
        end
    endtask

    task automatic write_cfg(input kmouse_pkg::kmouse_cfg_t c);
        @(negedge clk);
        addr  = kmouse_pkg::KM_ADDR_CFG;
        wdata = {6'b000000, c};
        wr    = 1'b1;
        @(negedge clk);
        wr = 1'b0;
        model_cfg = c;
        readback_cfg(c);
    endtask

    // Data changes while ps2_clk is high as a mouse does it
    task automatic send_frame(
        input logic [7:0] data,
        input logic       bad_parity,
        input logic       bad_stop
    );
        logic [10:0] frame;
        frame = {~bad_stop, (~^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            repeat (BIT_CYCLES / 4) @(negedge clk);
            ps2_data = frame[i];
            repeat (BIT_CYCLES / 4) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (BIT_CYCLES / 2) @(negedge clk);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        idle_cycles(BYTE_GAP);
    endtask

    // Hand the expected state to the checker and wait for it
    task automatic post_check();
        exp_pos    = model_pos;
        pkt_posted = pkt_posted + 1;
        wait (pkt_checked == pkt_posted);
    endtask

    task automatic send_packet(input logic [7:0] b1, input logic [7:0] b2, input logic [7:0] b3);
        send_frame(b1, 1'b0, 1'b0);
        send_frame(b2, 1'b0, 1'b0);
        send_frame(b3, 1'b0, 1'b0);
        idle_cycles(PACKET_GAP);
        model_pos = kmouse_model(model_pos, b1, b2, b3, model_cfg);
        post_check();
    endtask

    task automatic send_random_packet();
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b1 = rand_byte() | 8'h08;
        b2 = rand_byte();
        b3 = rand_byte();
        send_packet(b1, b2, b3);
    endtask

    //////////////////////////////////////////////////
    // Checker process
    //////////////////////////////////////////////////

    initial begin : compare_proc
        kmouse_pkg::kmouse_pos_t got;
        forever begin
            wait (pkt_posted > pkt_checked);
            host_read(kmouse_pkg::KM_ADDR_X, got.x);
            host_read(kmouse_pkg::KM_ADDR_Y, got.y);
            host_read(kmouse_pkg::KM_ADDR_BUTTONS, got.buttons);
            check_pos(exp_pos, got);
            pkt_checked = pkt_checked + 1;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin : stimulus
        kmouse_pkg::kmouse_cfg_t cfg_list [3];
        rst_n    = 1'b0;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        addr     = kmouse_pkg::KM_ADDR_X;
        rd       = 1'b0;
        wr       = 1'b0;
        wdata    = 8'h00;
        model_pos = '{x: 8'h00, y: 8'h00, buttons: kmouse_pkg::KM_BUTTONS_IDLE};
        model_cfg = '0;
        cfg_list[0] = '{swap_buttons: 1'b1, invert_y: 1'b0};
        cfg_list[1] = '{swap_buttons: 1'b0, invert_y: 1'b1};
        cfg_list[2] = '{swap_buttons: 1'b1, invert_y: 1'b1};
        idle_cycles(16);
        rst_n = 1'b1;
        idle_cycles(4);

        // Reset values
        post_check();
        readback_cfg('0);

        repeat (40) send_random_packet();

        // Swap, invert, then both
        for (int i = 0; i < 3; i++) begin
            write_cfg(cfg_list[i]);
            // Left button only and a nonzero dy so swap and invert both show
            send_packet(8'h09, 8'h05, 8'h03);
            repeat (4) send_random_packet();
        end
        write_cfg('0);

        // Bad parity in byte two followed by an idle gap
        send_frame(rand_byte() | 8'h08, 1'b0, 1'b0);
        send_frame(rand_byte(), 1'b1, 1'b0);
        send_frame(rand_byte(), 1'b0, 1'b0);
        idle_cycles(TIMEOUT + 200);
        post_check();
        send_random_packet();

        // Byte one without the sync bit
        send_frame(rand_byte() & 8'hF7, 1'b0, 1'b0);
        send_random_packet();

        // Third byte lost to a bad stop bit so the packet stalls
        send_frame(rand_byte() | 8'h08, 1'b0, 1'b0);
        send_frame(rand_byte(), 1'b0, 1'b0);
        send_frame(rand_byte(), 1'b0, 1'b1);
        idle_cycles(TIMEOUT + 200);
        post_check();
        send_random_packet();

        $display("Errors: pos %0d, cfg %0d, read strobe %0d",
                 pos_errors, cfg_errors, strobe_errors);
        if (pos_errors + cfg_errors + strobe_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/kmouse_pkg.sv
hdl/ps2_rx.sv
hdl/ps2_packet_decoder.sv
hdl/kmouse_regs.sv
hdl/kmouse_top.sv
tb/tb_kmouse.sv
